// ==== hw/button_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module button_sync (
	input  wire  clk,
	input  wire  reset,
	input  wire  left,
	input  wire  right,
	input  wire  up,
	input  wire  down,
	input  wire  set_speed,
	output logic left_sync,
	output logic right_sync,
	output logic up_sync,
	output logic down_sync,
	output logic set_speed_sync
);

	logic [4:0] raw;
	logic [4:0] meta; // first stage, may go metastable.
	logic [4:0] sync;

	assign raw = {left, right, up, down, set_speed};

	// two flops on every level. Nothing downstream looks at the pins.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			meta <= '0;
			sync <= '0;
		end else begin
			meta <= raw;
			sync <= meta;
		end
	end

	assign left_sync      = sync[4];
	assign right_sync     = sync[3];
	assign up_sync        = sync[2];
	assign down_sync      = sync[1];
	assign set_speed_sync = sync[0];

endmodule

`default_nettype wire

// ==== hw/sprite_move_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module sprite_move_fsm (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     left_sync,
	input  wire                     right_sync,
	input  wire                     up_sync,
	input  wire                     down_sync,
	input  wire                     set_speed_sync,
	input  sprite_pkg::speed_code_t speed_code,
	output sprite_pkg::direction_t  direction,
	output logic                    step
);

	sprite_pkg::direction_t  next_direction;
	sprite_pkg::direction_t  held_direction; // the one button held, idle if not exactly one.
	sprite_pkg::step_count_t limit;
	sprite_pkg::step_count_t limit_next;
	sprite_pkg::step_count_t count;
	logic                    counting;

	// ------------------------------------------------------------------------
	// heading state machine
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			direction <= sprite_pkg::dir_idle;
		else
			direction <= next_direction;
	end

	// Each heading has its own priority order; with no button it holds.
	always_comb begin
		next_direction = direction;
		case (direction)
			sprite_pkg::dir_idle: begin
				if (left_sync)       next_direction = sprite_pkg::dir_left;
				else if (right_sync) next_direction = sprite_pkg::dir_right;
				else if (up_sync)    next_direction = sprite_pkg::dir_up;
				else if (down_sync)  next_direction = sprite_pkg::dir_down;
			end
			sprite_pkg::dir_left: begin
				if (right_sync)      next_direction = sprite_pkg::dir_right;
				else if (up_sync)    next_direction = sprite_pkg::dir_up;
				else if (down_sync)  next_direction = sprite_pkg::dir_down;
			end
			sprite_pkg::dir_right: begin
				if (left_sync)       next_direction = sprite_pkg::dir_left;
				else if (up_sync)    next_direction = sprite_pkg::dir_up;
				else if (down_sync)  next_direction = sprite_pkg::dir_down;
			end
			sprite_pkg::dir_up: begin
				if (up_sync)         next_direction = sprite_pkg::dir_up;
				else if (down_sync)  next_direction = sprite_pkg::dir_down;
				else if (right_sync) next_direction = sprite_pkg::dir_right;
				else if (left_sync)  next_direction = sprite_pkg::dir_left;
			end
			sprite_pkg::dir_down: begin
				if (up_sync)         next_direction = sprite_pkg::dir_up;
				else if (right_sync) next_direction = sprite_pkg::dir_right;
				else if (left_sync)  next_direction = sprite_pkg::dir_left;
			end
			default: next_direction = sprite_pkg::dir_idle;
		endcase
	end

	// ------------------------------------------------------------------------
	// speed limit
	// ------------------------------------------------------------------------

	always_comb begin
		case (speed_code)
			3'd2:    limit_next = sprite_pkg::base_period / 2;
			3'd3:    limit_next = sprite_pkg::base_period / 3;
			3'd4:    limit_next = sprite_pkg::base_period / 4;
			3'd5:    limit_next = sprite_pkg::base_period / 5;
			3'd6:    limit_next = sprite_pkg::base_period / 6;
			3'd7:    limit_next = sprite_pkg::base_period / 7;
			default: limit_next = sprite_pkg::base_period; // codes 0 and 1.
		endcase
	end

	// speed_code is only looked at on the strobe, so it needs no synchronizer.
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			limit <= sprite_pkg::base_period;
		else if (set_speed_sync)
			limit <= limit_next;
	end

	// ------------------------------------------------------------------------
	// step rate counter
	// ------------------------------------------------------------------------

	always_comb begin
		case ({left_sync, right_sync, up_sync, down_sync})
			4'b1000: held_direction = sprite_pkg::dir_left;
			4'b0100: held_direction = sprite_pkg::dir_right;
			4'b0010: held_direction = sprite_pkg::dir_up;
			4'b0001: held_direction = sprite_pkg::dir_down;
			default: held_direction = sprite_pkg::dir_idle;
		endcase
	end

	assign counting = (held_direction != sprite_pkg::dir_idle) &&
	                  (held_direction == direction);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			step  <= 1'b0;
		end else if (!counting) begin
			count <= '0; // any break in the hold restarts the full period.
			step  <= 1'b0;
		end else if (count >= limit) begin // >= covers a limit lowered mid-count.
			count <= '0;
			step  <= 1'b1;
		end else begin
			count <= count + 1'b1;
			step  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/sprite_mover_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sprite_mover_top (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     left,
	input  wire                     right,
	input  wire                     up,
	input  wire                     down,
	input  wire                     set_speed,
	input  sprite_pkg::speed_code_t speed_code,
	output sprite_pkg::direction_t  direction,
	output logic                    step,
	output sprite_pkg::coord_x_t    sprite_x,
	output sprite_pkg::coord_y_t    sprite_y
);

	logic left_sync;
	logic right_sync;
	logic up_sync;
	logic down_sync;
	logic set_speed_sync;

	// buttons are asynchronous, so they pass through the synchronizer first.
	button_sync u_button_sync (
		.clk            (clk),
		.reset          (reset),
		.left           (left),
		.right          (right),
		.up             (up),
		.down           (down),
		.set_speed      (set_speed),
		.left_sync      (left_sync),
		.right_sync     (right_sync),
		.up_sync        (up_sync),
		.down_sync      (down_sync),
		.set_speed_sync (set_speed_sync)
	);

	sprite_move_fsm u_sprite_move_fsm (
		.clk            (clk),
		.reset          (reset),
		.left_sync      (left_sync),
		.right_sync     (right_sync),
		.up_sync        (up_sync),
		.down_sync      (down_sync),
		.set_speed_sync (set_speed_sync),
		.speed_code     (speed_code),
		.direction      (direction),
		.step           (step)
	);

	sprite_position u_sprite_position (
		.clk       (clk),
		.reset     (reset),
		.step      (step),
		.direction (direction),
		.sprite_x  (sprite_x),
		.sprite_y  (sprite_y)
	);

endmodule

`default_nettype wire

// ==== hw/sprite_pkg.sv ====
`default_nettype none

package sprite_pkg;

	// ------------------------------------------------------------------------
	// types
	// ------------------------------------------------------------------------

	// heading of the sprite, encoded as in the older controller.
	typedef enum logic [2:0] {
		dir_idle  = 3'd0,
		dir_left  = 3'd1,
		dir_right = 3'd2,
		dir_up    = 3'd3,
		dir_down  = 3'd4
	} direction_t;

	typedef logic [2:0] speed_code_t; // 0 and 1 both select the slowest rate.
	typedef logic [8:0] step_count_t; // wide enough for the longest period.
	typedef logic [9:0] coord_x_t;
	typedef logic [8:0] coord_y_t;

	// ------------------------------------------------------------------------
	// screen geometry and timing
	// ------------------------------------------------------------------------

	// divisible by every code from 1 to 7, so each limit is exact.
	localparam step_count_t base_period = 9'd420;

	localparam int sprite_size   = 16;
	localparam int screen_width  = 640;
	localparam int screen_height = 480;

	// the corner may not go past these, or part of the sprite is off screen.
	localparam coord_x_t max_x = coord_x_t'(screen_width - sprite_size);
	localparam coord_y_t max_y = coord_y_t'(screen_height - sprite_size);

	// the sprite starts centred.
	localparam coord_x_t start_x = coord_x_t'((screen_width - sprite_size) / 2);
	localparam coord_y_t start_y = coord_y_t'((screen_height - sprite_size) / 2);

endpackage

`default_nettype wire

// ==== hw/sprite_position.sv ====
`timescale 1ns/100ps
`default_nettype none

module sprite_position (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    step,
	input  sprite_pkg::direction_t direction,
	output sprite_pkg::coord_x_t   sprite_x,
	output sprite_pkg::coord_y_t   sprite_y
);

	sprite_pkg::coord_x_t x_next;
	sprite_pkg::coord_y_t y_next;

	// ------------------------------------------------------------------------
	// next position, one pixel per step, held at the screen edges
	// ------------------------------------------------------------------------

	always_comb begin
		x_next = sprite_x;
		y_next = sprite_y;
		case (direction)
			sprite_pkg::dir_left: begin
				if (sprite_x != '0)
					x_next = sprite_x - 1'b1;
			end
			sprite_pkg::dir_right: begin
				if (sprite_x < sprite_pkg::max_x)
					x_next = sprite_x + 1'b1;
			end
			sprite_pkg::dir_up: begin
				if (sprite_y != '0)
					y_next = sprite_y - 1'b1;
			end
			sprite_pkg::dir_down: begin
				if (sprite_y < sprite_pkg::max_y)
					y_next = sprite_y + 1'b1;
			end
			default: begin
				// idle heading leaves the sprite where it is.
			end
		endcase
	end

	// coordinates are the top-left corner of the 16 by 16 sprite.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sprite_x <= sprite_pkg::start_x;
			sprite_y <= sprite_pkg::start_y;
		end else if (step) begin
			sprite_x <= x_next;
			sprite_y <= y_next;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module sprite_mover_tb -f sim.f

output="$(./obj_dir/Vsprite_mover_tb)"
echo "$output"

if echo "$output" | grep -q "Finished with no errors"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== sim.f ====
hw/sprite_pkg.sv
hw/button_sync.sv
hw/sprite_move_fsm.sv
hw/sprite_position.sv
hw/sprite_mover_top.sv
sim/sprite_mover_sva.sv
sim/sprite_mover_tb.sv

// ==== sim/sprite_mover_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module sprite_mover_sva (
	input wire                    clk,
	input wire                    reset,
	input wire                    step,
	input sprite_pkg::direction_t direction,
	input sprite_pkg::coord_x_t   sprite_x,
	input sprite_pkg::coord_y_t   sprite_y
);

	// a step lasts one cycle, the counter restarts from zero after it.
	assert property (@(posedge clk) disable iff (reset) step |=> !step)
		else $error("step was high on two consecutive cycles.");

	assert property (@(posedge clk) disable iff (reset) sprite_x <= sprite_pkg::max_x)
		else $error("sprite_x went past the right edge of the screen.");

	assert property (@(posedge clk) disable iff (reset) sprite_y <= sprite_pkg::max_y)
		else $error("sprite_y went past the bottom edge of the screen.");

	assert property (@(posedge clk) $fell(reset) |-> direction == sprite_pkg::dir_idle)
		else $error("direction was not idle when reset was released.");

endmodule

bind sprite_mover_top sprite_mover_sva u_sprite_mover_sva (
	.clk       (clk),
	.reset     (reset),
	.step      (step),
	.direction (direction),
	.sprite_x  (sprite_x),
	.sprite_y  (sprite_y)
);

`default_nettype wire

// ==== sim/sprite_mover_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module sprite_mover_tb;

	localparam int clk_period = 8;
	localparam int max_rows   = 32;

	logic                    clk;
	logic                    reset;
	logic                    left;
	logic                    right;
	logic                    up;
	logic                    down;
	logic                    set_speed;
	sprite_pkg::speed_code_t speed_code;
	sprite_pkg::direction_t  direction;
	logic                    step;
	sprite_pkg::coord_x_t    sprite_x;
	sprite_pkg::coord_y_t    sprite_y;

	// stimulus table, buttons are packed as {left, right, up, down}.
	string                   row_name [max_rows];
	logic [2:0]              row_code [max_rows];
	logic                    row_set [max_rows];
	logic [3:0]              row_buttons [max_rows];
	int                      row_hold [max_rows];
	sprite_pkg::direction_t  exp_dir [max_rows];
	int                      exp_steps [max_rows];
	int                      exp_x [max_rows];
	int                      exp_y [max_rows];
	int                      row_count;
	int                      timeout_cycles;
	logic                    table_ready;
	int                      error_count;
	int                      failed_tests;
	logic [31:0]             lfsr_state;

	// reference model registers.
	logic [4:0]              m_meta;
	logic [4:0]              m_sync;
	sprite_pkg::direction_t  m_dir;
	int                      m_limit;
	int                      m_count;
	logic                    m_step;
	int                      m_x;
	int                      m_y;

	sprite_mover_top dut (
		.clk        (clk),
		.reset      (reset),
		.left       (left),
		.right      (right),
		.up         (up),
		.down       (down),
		.set_speed  (set_speed),
		.speed_code (speed_code),
		.direction  (direction),
		.step       (step),
		.sprite_x   (sprite_x),
		.sprite_y   (sprite_y)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------

	function automatic logic is_pressed(input sprite_pkg::direction_t dir,
	                                    input logic [3:0] buttons);
		case (dir)
			sprite_pkg::dir_left:  return buttons[3];
			sprite_pkg::dir_right: return buttons[2];
			sprite_pkg::dir_up:    return buttons[1];
			sprite_pkg::dir_down:  return buttons[0];
			default:               return 1'b0;
		endcase
	endfunction

	// first pressed button in the order of the current heading wins.
	function automatic sprite_pkg::direction_t pick_heading(input sprite_pkg::direction_t current,
	                                                        input logic [3:0] buttons);
		sprite_pkg::direction_t order [4];
		sprite_pkg::direction_t result;
		logic                   found;
		result = current;
		found  = 1'b0;
		case (current)
			sprite_pkg::dir_left:  order = '{sprite_pkg::dir_right, sprite_pkg::dir_up,
			                                 sprite_pkg::dir_down, sprite_pkg::dir_idle};
			sprite_pkg::dir_right: order = '{sprite_pkg::dir_left, sprite_pkg::dir_up,
			                                 sprite_pkg::dir_down, sprite_pkg::dir_idle};
			sprite_pkg::dir_up:    order = '{sprite_pkg::dir_up, sprite_pkg::dir_down,
			                                 sprite_pkg::dir_right, sprite_pkg::dir_left};
			sprite_pkg::dir_down:  order = '{sprite_pkg::dir_up, sprite_pkg::dir_right,
			                                 sprite_pkg::dir_left, sprite_pkg::dir_idle};
			default:               order = '{sprite_pkg::dir_left, sprite_pkg::dir_right,
			                                 sprite_pkg::dir_up, sprite_pkg::dir_down};
		endcase
		for (int i = 0; i < 4; i++) begin
			if (!found && is_pressed(order[i], buttons)) begin
				result = order[i];
				found  = 1'b1;
			end
		end
		return result;
	endfunction

	function automatic int limit_for(input logic [2:0] code);
		if (code == 3'd0)
			return int'(sprite_pkg::base_period);
		else
			return int'(sprite_pkg::base_period) / int'(code);
	endfunction

	// one rising edge, every register computed from the values before it.
	task automatic model_clock(input logic [3:0] buttons, input logic set_in,
	                           input logic [2:0] code);
		logic counting;
		if (m_step) begin
			case (m_dir)
				sprite_pkg::dir_left:  m_x = (m_x > 0) ? m_x - 1 : m_x;
				sprite_pkg::dir_right: m_x = (m_x < int'(sprite_pkg::max_x)) ? m_x + 1 : m_x;
				sprite_pkg::dir_up:    m_y = (m_y > 0) ? m_y - 1 : m_y;
				sprite_pkg::dir_down:  m_y = (m_y < int'(sprite_pkg::max_y)) ? m_y + 1 : m_y;
				default: ;
			endcase
		end
		counting = ($countones(m_sync[4:1]) == 1) && is_pressed(m_dir, m_sync[4:1]);
		m_step = counting && (m_count >= m_limit); // the strobe fires as the count reaches the limit.
		m_count = (!counting || m_step) ? 0 : m_count + 1;
		if (m_sync[0])
			m_limit = limit_for(code);
		m_dir  = pick_heading(m_dir, m_sync[4:1]);
		m_sync = m_meta;
		m_meta = {buttons, set_in};
	endtask

	task automatic predict_table();
		m_meta  = '0;
		m_sync  = '0;
		m_dir   = sprite_pkg::dir_idle;
		m_limit = int'(sprite_pkg::base_period);
		m_count = 0;
		m_step  = 1'b0;
		m_x     = int'(sprite_pkg::start_x);
		m_y     = int'(sprite_pkg::start_y);
		for (int r = 0; r < row_count; r++) begin
			exp_steps[r] = 0;
			for (int c = 0; c < row_hold[r]; c++) begin
				model_clock(row_buttons[r], row_set[r], row_code[r]);
				if (m_step)
					exp_steps[r]++;
			end
			exp_dir[r] = m_dir;
			exp_x[r]   = m_x;
			exp_y[r]   = m_y;
		end
	endtask

	// ------------------------------------------------------------------------
	// stimulus table
	// ------------------------------------------------------------------------

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h8020_0003;
		else
			return state >> 1;
	endfunction

	task automatic take_random(input int bits, output int value);
		value = 0;
		for (int i = 0; i < bits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value      = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic add_row(input string name, input logic [2:0] code, input logic set_in,
	                       input logic [3:0] buttons, input int hold);
		row_name[row_count]    = name;
		row_code[row_count]    = code;
		row_set[row_count]     = set_in;
		row_buttons[row_count] = buttons;
		row_hold[row_count]    = hold;
		row_count++;
	endtask

	task automatic build_table();
		int hold;
		row_count = 0;
		add_row("reset_idle",      3'd0, 1'b0, 4'b0000, 20);
		add_row("idle_left_right", 3'd0, 1'b0, 4'b1100, 8);
		add_row("left_up_right",   3'd0, 1'b0, 4'b0110, 8);
		add_row("right_left_down", 3'd0, 1'b0, 4'b1001, 8);
		add_row("left_up_down",    3'd0, 1'b0, 4'b0011, 8);
		add_row("up_up_down",      3'd0, 1'b0, 4'b0011, 8);
		add_row("up_right_left",   3'd0, 1'b0, 4'b1100, 8);
		add_row("right_down",      3'd0, 1'b0, 4'b0001, 8);
		add_row("down_all",        3'd0, 1'b0, 4'b1111, 8);
		add_row("up_down_left",    3'd0, 1'b0, 4'b1001, 8);
		add_row("down_right_left", 3'd0, 1'b0, 4'b1100, 8);
		add_row("release_holds",   3'd0, 1'b0, 4'b0000, 8);
		add_row("load_code0",      3'd0, 1'b1, 4'b0000, 6);
		add_row("code0_right",     3'd0, 1'b0, 4'b0100, 900);
		add_row("load_code3",      3'd3, 1'b1, 4'b0000, 6);
		add_row("code3_right",     3'd3, 1'b0, 4'b0100, 600);
		add_row("load_code7",      3'd7, 1'b1, 4'b0000, 6);
		add_row("code7_right",     3'd7, 1'b0, 4'b0100, 400);
		add_row("two_buttons",     3'd7, 1'b0, 4'b0110, 200);
		// ends one cycle before the first step of a cleared counter.
		add_row("up_after_clear",  3'd7, 1'b0, 4'b0010, 62);
		add_row("up_first_step",   3'd7, 1'b0, 4'b0010, 1);
		add_row("turn_left",       3'd7, 1'b0, 4'b1000, 200);
		add_row("clamp_left",      3'd7, 1'b0, 4'b1000, 22000);
		add_row("clamp_up",        3'd7, 1'b0, 4'b0010, 16000);
		add_row("clamp_right",     3'd7, 1'b0, 4'b0100, 40000);
		add_row("clamp_down",      3'd7, 1'b0, 4'b0001, 30000);
		add_row("code_no_load",    3'd2, 1'b0, 4'b0010, 300); // limit stays at 60.
		take_random(8, hold);
		add_row("random_left",     3'd2, 1'b0, 4'b1000, 40 + hold);
		take_random(8, hold);
		add_row("random_down",     3'd2, 1'b0, 4'b0001, 40 + hold);
		take_random(8, hold);
		add_row("random_right",    3'd2, 1'b0, 4'b0100, 40 + hold);
		take_random(8, hold);
		add_row("random_up",       3'd2, 1'b0, 4'b0010, 40 + hold);
	endtask

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	task automatic check_value(input string test, input string field, input int expected,
	                           input int actual, inout int errors);
		if (expected != actual) begin
			$display("MISMATCH %s %s expected %0d actual %0d", test, field, expected, actual);
			errors++;
		end
	endtask

	task automatic run_row(input int r);
		int steps;
		int row_errors;
		{left, right, up, down} = row_buttons[r];
		set_speed  = row_set[r];
		speed_code = row_code[r];
		steps      = 0;
		row_errors = 0;
		for (int c = 0; c < row_hold[r]; c++) begin
			@(posedge clk);
			#1;
			if (step)
				steps++;
		end
		check_value(row_name[r], "direction", int'(exp_dir[r]), int'(direction), row_errors);
		check_value(row_name[r], "steps", exp_steps[r], steps, row_errors);
		check_value(row_name[r], "sprite_x", exp_x[r], int'(sprite_x), row_errors);
		check_value(row_name[r], "sprite_y", exp_y[r], int'(sprite_y), row_errors);
		if (row_errors == 0)
			$display("test %s passed: direction %0d, %0d steps, position (%0d, %0d)",
			         row_name[r], int'(exp_dir[r]), exp_steps[r], exp_x[r], exp_y[r]);
		else begin
			$display("test %s failed with %0d errors", row_name[r], row_errors);
			failed_tests++;
		end
		error_count += row_errors;
	endtask

	initial begin
		reset        = 1'b1;
		left         = 1'b0;
		right        = 1'b0;
		up           = 1'b0;
		down         = 1'b0;
		set_speed    = 1'b0;
		speed_code   = '0;
		error_count  = 0;
		failed_tests = 0;
		table_ready  = 1'b0;
		lfsr_state   = 32'h7bc5_8790;
		build_table();
		predict_table();
		timeout_cycles = 100;
		for (int r = 0; r < row_count; r++)
			timeout_cycles += row_hold[r];
		table_ready = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int r = 0; r < row_count; r++)
			run_row(r);
		$display("%0d tests run, %0d failed, %0d errors", row_count, failed_tests, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		wait (table_ready);
		#(timeout_cycles * clk_period);
		$display("timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
